// ==== project.f ====
source/glb_csb_pkg.sv
source/glb_reg_pkg.sv
source/glb_csb.sv
source/glb_csb_reg.sv
source/glb_intr.sv
source/glb_top.sv
verification/glb_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
rm -f sim.log \
  && verilator --binary --timing --assert -f project.f --top-module glb_tb -o glb_sim \
  && ./obj_dir/glb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"

// ==== source/glb_csb.sv ====
`timescale 1ns/1ps

module glb_csb (
  input  logic                                     nvdla_core_clk,
  input  logic                                     nvdla_core_rstn,
  input  logic                                     csb2glb_req_pvld,
  input  logic [glb_csb_pkg::csb_req_width-1:0]    csb2glb_req_pd,
  output logic                                     csb2glb_req_prdy,
  output logic                                     glb2csb_resp_valid,
  output logic [glb_csb_pkg::csb_resp_width-1:0]   glb2csb_resp_pd,
  output logic                                     reg_wr_en,
  output logic [glb_reg_pkg::reg_offset_width-1:0] reg_offset,
  output logic [31:0]                              reg_wr_data,
  input  logic [31:0]                              reg_rd_data
);
  import glb_csb_pkg::*;

  logic                        req_vld;
  logic [csb_req_width-1:0]    req_pd;
  logic [req_addr_width-1:0]   req_addr;
  logic [31:0]                 req_wdat;
  logic                        req_write;
  logic                        req_nposted;
  logic                        rsp_rd_vld;
  logic                        rsp_wr_vld;
  logic                        rsp_vld;
  logic [csb_resp_width-1:0]   rsp_pd;

  assign csb2glb_req_prdy = 1'b1; // never back-pressures

  ////////////////////////////////////////////////////////////////////////////
  // request capture
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_vld <= 1'b0;
    end else begin
      req_vld <= csb2glb_req_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (csb2glb_req_pvld) begin
      req_pd <= csb2glb_req_pd;
    end
  end

  assign req_addr    = req_pd[req_addr_msb:req_addr_lsb];
  assign req_wdat    = req_pd[req_wdat_msb:req_wdat_lsb];
  assign req_write   = req_pd[req_write_bit];
  assign req_nposted = req_pd[req_nposted_bit];

  // register port, word address to byte offset
  assign reg_wr_en   = req_vld & req_write;
  assign reg_offset  = {req_addr[9:0], 2'b00};
  assign reg_wr_data = req_wdat;

  ////////////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////////////
  assign rsp_rd_vld = req_vld & ~req_write;
  assign rsp_wr_vld = req_vld & req_write & req_nposted; // posted writes stay silent
  assign rsp_vld    = rsp_rd_vld | rsp_wr_vld;

  always_comb begin
    rsp_pd                 = '0;
    rsp_pd[resp_error_bit] = 1'b0;                 // no error path
    rsp_pd[resp_type_bit]  = rsp_wr_vld ? resp_type_write : resp_type_read;
    if (rsp_rd_vld) begin
      rsp_pd[resp_data_msb:resp_data_lsb] = reg_rd_data;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      glb2csb_resp_valid <= 1'b0;
    end else begin
      glb2csb_resp_valid <= rsp_vld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rsp_vld) begin
      glb2csb_resp_pd <= rsp_pd;
    end
  end

  // a response is always two cycles behind a bus request
  a_resp_has_req: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    glb2csb_resp_valid |-> $past(req_vld));

endmodule

// ==== source/glb_csb_pkg.sv ====
package glb_csb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // request word layout
  ////////////////////////////////////////////////////////////////////////////
  localparam int req_addr_lsb    = 0;
  localparam int req_addr_msb    = 21;
  localparam int req_addr_width  = req_addr_msb - req_addr_lsb + 1;

  localparam int req_wdat_lsb    = req_addr_msb + 1;  // 22
  localparam int req_wdat_msb    = req_wdat_lsb + 31; // 53

  localparam int req_write_bit   = req_wdat_msb + 1;  // 54
  localparam int req_nposted_bit = req_write_bit + 1; // 55
  localparam int req_priv_bit    = req_nposted_bit + 1;

  // byte enables and level ride along, no logic looks at them
  localparam int req_be_width    = 4;
  localparam int req_be_lsb      = req_priv_bit + 1;  // 57
  localparam int req_level_width = 2;
  localparam int req_level_lsb   = req_be_lsb + req_be_width; // 61

  localparam int csb_req_width   = req_level_lsb + req_level_width; // 63

  ////////////////////////////////////////////////////////////////////////////
  // response word layout
  ////////////////////////////////////////////////////////////////////////////
  localparam int resp_data_lsb   = 0;
  localparam int resp_data_msb   = 31;
  localparam int resp_error_bit  = resp_data_msb + 1;  // 32
  localparam int resp_type_bit   = resp_error_bit + 1; // 33

  localparam int csb_resp_width  = resp_type_bit + 1;  // 34

  // type field codes
  localparam logic resp_type_read  = 1'b0;
  localparam logic resp_type_write = 1'b1;

endpackage

// ==== source/glb_csb_reg.sv ====
`timescale 1ns/1ps

module glb_csb_reg (
  input  logic                                     nvdla_core_clk,
  input  logic                                     nvdla_core_rstn,
  input  logic                                     reg_wr_en,
  input  logic [glb_reg_pkg::reg_offset_width-1:0] reg_offset,
  input  logic [31:0]                              reg_wr_data,
  output logic [31:0]                              reg_rd_data,
  input  glb_reg_pkg::intr_word_u                  intr_status,
  output glb_reg_pkg::intr_word_u                  intr_mask,
  output glb_reg_pkg::intr_word_u                  intr_set,
  output glb_reg_pkg::intr_word_u                  intr_clr
);
  import glb_reg_pkg::*;

  logic sel_mask;
  logic sel_set;
  logic sel_status;
  logic wr_mask;
  logic wr_set;
  logic wr_clr;
  logic [31:0] wr_live; // write data limited to implemented bits

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////
  assign sel_mask   = (reg_offset == reg_intr_mask);
  assign sel_set    = (reg_offset == reg_intr_set);
  assign sel_status = (reg_offset == reg_intr_status);

  assign wr_mask = reg_wr_en & sel_mask;
  assign wr_set  = reg_wr_en & sel_set;
  assign wr_clr  = reg_wr_en & sel_status; // w1c on status

  assign wr_live = reg_wr_data & intr_live_mask;

  ////////////////////////////////////////////////////////////////////////////
  // mask register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      intr_mask.word <= intr_live_mask; // everything masked out of reset
    end else if (wr_mask) begin
      intr_mask.word <= wr_live;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // set / clear pulses, high one cycle after the write
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      intr_set.word <= '0;
      intr_clr.word <= '0;
    end else begin
      intr_set.word <= wr_set ? wr_live : 32'h0; // self clearing
      intr_clr.word <= wr_clr ? wr_live : 32'h0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (reg_offset)
      reg_version:     reg_rd_data = glb_version;
      reg_intr_mask:   reg_rd_data = intr_mask.word;
      reg_intr_set:    reg_rd_data = 32'h0;          // write only
      reg_intr_status: reg_rd_data = intr_status.word;
      default:         reg_rd_data = 32'h0;
    endcase
  end

  // one request per cycle, so set and clear never pulse together
  a_set_clr_excl: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !((|intr_set.word) && (|intr_clr.word)));

endmodule

// ==== source/glb_intr.sv ====
`timescale 1ns/1ps

module glb_intr (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  input  logic [1:0]              sdp_done,
  input  logic [1:0]              cdma_dat_done,
  input  logic [1:0]              cdma_wt_done,
  input  logic [1:0]              cacc_done,
  input  glb_reg_pkg::intr_word_u intr_set,
  input  glb_reg_pkg::intr_word_u intr_clr,
  input  glb_reg_pkg::intr_word_u intr_mask,
  output glb_reg_pkg::intr_word_u intr_status,
  output logic                    core_intr
);
  import glb_reg_pkg::*;

  intr_word_u done_w;
  logic [31:0] status_nxt;
  logic [31:0] pending; // unmasked and set

  ////////////////////////////////////////////////////////////////////////////
  // engine done pulses into their fields
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    done_w.word         = '0; // cdp, pdp, bdma, rubik stay zero
    done_w.eng.sdp      = sdp_done;
    done_w.eng.cdma_dat = cdma_dat_done;
    done_w.eng.cdma_wt  = cdma_wt_done;
    done_w.eng.cacc     = cacc_done;
  end

  ////////////////////////////////////////////////////////////////////////////
  // status update
  ////////////////////////////////////////////////////////////////////////////
  // set or done beats a clear on the same bit
  assign status_nxt = ((intr_set.word | done_w.word)
                      | (intr_status.word & ~intr_clr.word))
                      & intr_live_mask;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      intr_status.word <= '0;
    end else begin
      intr_status.word <= status_nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // core interrupt
  ////////////////////////////////////////////////////////////////////////////
  assign pending   = intr_status.word & ~intr_mask.word;
  assign core_intr = |pending;

  // bits for absent engines never show up in status
  a_rsvd_zero: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (intr_status.word & ~intr_live_mask) == 32'h0);

endmodule

// ==== source/glb_reg_pkg.sv ====
package glb_reg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////////////
  localparam int reg_offset_width = 12;

  localparam logic [reg_offset_width-1:0] reg_version     = 12'h000;
  localparam logic [reg_offset_width-1:0] reg_intr_mask   = 12'h004;
  localparam logic [reg_offset_width-1:0] reg_intr_set    = 12'h008; // write-one-to-set
  localparam logic [reg_offset_width-1:0] reg_intr_status = 12'h00c; // write-one-to-clear

  localparam logic [31:0] glb_version = 32'h0001_0003;

  ////////////////////////////////////////////////////////////////////////////
  // interrupt word, two bits per engine (group 0 / group 1)
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [9:0] rsvd_hi;
    logic [1:0] cacc;
    logic [1:0] cdma_wt;
    logic [1:0] cdma_dat;
    logic [5:0] rsvd_lo;
    logic [1:0] rubik;    // not present in this core
    logic [1:0] bdma;     // not present in this core
    logic [1:0] pdp;      // not present in this core
    logic [1:0] cdp;      // not present in this core
    logic [1:0] sdp;
  } intr_fields_t;

  typedef union packed {
    logic [31:0]  word; // bus view
    intr_fields_t eng;  // per engine view
  } intr_word_u;

  // sdp, cdma_dat, cdma_wt, cacc
  localparam logic [31:0] intr_live_mask = 32'h003f_0003;

endpackage

// ==== source/glb_top.sv ====
`timescale 1ns/1ps

module glb_top (
  input  logic                                   nvdla_core_clk,
  input  logic                                   nvdla_core_rstn,
  input  logic                                   csb2glb_req_pvld,
  input  logic [glb_csb_pkg::csb_req_width-1:0]  csb2glb_req_pd,
  output logic                                   csb2glb_req_prdy,
  output logic                                   glb2csb_resp_valid,
  output logic [glb_csb_pkg::csb_resp_width-1:0] glb2csb_resp_pd,
  input  logic [1:0]                             sdp_done,
  input  logic [1:0]                             cdma_dat_done,
  input  logic [1:0]                             cdma_wt_done,
  input  logic [1:0]                             cacc_done,
  output logic                                   core_intr,
  output logic [31:0]                            intr_mask
);
  import glb_reg_pkg::*;

  logic                        reg_wr_en;
  logic [reg_offset_width-1:0] reg_offset;
  logic [31:0]                 reg_wr_data;
  logic [31:0]                 reg_rd_data;
  intr_word_u                  intr_status;
  intr_word_u                  intr_mask_w;
  intr_word_u                  intr_set;
  intr_word_u                  intr_clr;

  assign intr_mask = intr_mask_w.word; // engines see their mask bits

  ////////////////////////////////////////////////////////////////////////////
  // bus front end, register file, interrupt state
  ////////////////////////////////////////////////////////////////////////////
  glb_csb u_csb (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .csb2glb_req_pvld   (csb2glb_req_pvld),
    .csb2glb_req_pd     (csb2glb_req_pd),
    .csb2glb_req_prdy   (csb2glb_req_prdy),
    .glb2csb_resp_valid (glb2csb_resp_valid),
    .glb2csb_resp_pd    (glb2csb_resp_pd),
    .reg_wr_en          (reg_wr_en),
    .reg_offset         (reg_offset),
    .reg_wr_data        (reg_wr_data),
    .reg_rd_data        (reg_rd_data)
  );

  glb_csb_reg u_reg (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .reg_wr_en       (reg_wr_en),
    .reg_offset      (reg_offset),
    .reg_wr_data     (reg_wr_data),
    .reg_rd_data     (reg_rd_data),
    .intr_status     (intr_status),
    .intr_mask       (intr_mask_w),
    .intr_set        (intr_set),
    .intr_clr        (intr_clr)
  );

  glb_intr u_intr (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .sdp_done        (sdp_done),
    .cdma_dat_done   (cdma_dat_done),
    .cdma_wt_done    (cdma_wt_done),
    .cacc_done       (cacc_done),
    .intr_set        (intr_set),
    .intr_clr        (intr_clr),
    .intr_mask       (intr_mask_w),
    .intr_status     (intr_status),
    .core_intr       (core_intr)
  );

endmodule

// ==== verification/glb_tb.sv ====
`timescale 1ns/1ps

module glb_tb;
  import glb_reg_pkg::*;

  localparam int max_cycles = 3000; // tests need about 110 cycles

  logic        nvdla_core_clk = 1'b0;
  logic        nvdla_core_rstn;
  logic        csb2glb_req_pvld;
  logic [62:0] csb2glb_req_pd;
  logic        csb2glb_req_prdy;
  logic        glb2csb_resp_valid;
  logic [33:0] glb2csb_resp_pd;
  logic [1:0]  sdp_done;
  logic [1:0]  cdma_dat_done;
  logic [1:0]  cdma_wt_done;
  logic [1:0]  cacc_done;
  logic        core_intr;
  logic [31:0] intr_mask;
  logic        cap_vld;        // request as the DUT holds it
  logic [62:0] cap_pd;
  logic [31:0] ref_mask;
  logic [31:0] ref_status;
  logic [31:0] ref_set;        // pulse words one cycle after the write
  logic [31:0] ref_clr;
  logic        exp_vld;
  logic [33:0] exp_pd;
  logic [31:0] rng;
  int          err_cnt = 0;
  int          chk_cnt = 0;
  int          cycles = 0;
  int          test_err;

  glb_top dut_i (.*);

  always #2 nvdla_core_clk = ~nvdla_core_clk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // level 0, all byte enables, no privilege, word address from the offset
  function automatic logic [62:0] make_req(input logic wr, input logic np,
                                           input logic [11:0] off, input logic [31:0] data);
    return {2'b00, 4'hf, 1'b0, np, wr, data, 12'h000, off[11:2]};
  endfunction

  // read data from the state the request sees, or a write ack
  function automatic logic [33:0] exp_resp(input logic [62:0] req, input logic [31:0] mask,
                                           input logic [31:0] status);
    logic [31:0] rd;
    case ({req[9:0], 2'b00})
      12'h000: rd = glb_version;
      12'h004: rd = mask;
      12'h00c: rd = status;
      default: rd = 32'h0; // set register and holes
    endcase
    return req[54] ? {1'b1, 33'h0} : {2'b00, rd};
  endfunction

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic drive(input logic vld, input logic [62:0] pd, input logic [7:0] dn);
    @(posedge nvdla_core_clk);
    #1;
    csb2glb_req_pvld = vld;
    csb2glb_req_pd   = pd;
    {cacc_done, cdma_wt_done, cdma_dat_done, sdp_done} = dn;
  endtask

  task automatic send(input logic wr, input logic np, input logic [11:0] off,
                      input logic [31:0] data);
    drive(1'b1, make_req(wr, np, off, data), 8'h00);
  endtask

  task automatic idle(input int n);
    repeat (n) drive(1'b0, 63'h0, 8'h00);
  endtask

  task automatic end_test(input string name);
    idle(4); // drain responses in flight
    $display("test %s finished with %0d errors", name, err_cnt - test_err);
    test_err = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin : ref_model
    logic        wr;
    logic [11:0] off;
    logic [31:0] wdat;
    logic [31:0] done;
    if (!nvdla_core_rstn) begin
      cap_vld    = 1'b0;
      cap_pd     = '0;
      ref_mask   = intr_live_mask; // all sources masked
      ref_status = 32'h0;
      ref_set    = 32'h0;
      ref_clr    = 32'h0;
      exp_vld    = 1'b0;
    end else begin
      wr   = cap_vld & cap_pd[54];
      off  = {cap_pd[9:0], 2'b00};
      wdat = cap_pd[53:22] & intr_live_mask;
      done = {10'h0, cacc_done, cdma_wt_done, cdma_dat_done, 14'h0, sdp_done};
      exp_vld = cap_vld & (~cap_pd[54] | cap_pd[55]); // posted writes are silent
      if (exp_vld) begin
        exp_pd = exp_resp(cap_pd, ref_mask, ref_status);
      end
      ref_status = (ref_set | done | (ref_status & ~ref_clr)) & intr_live_mask;
      ref_set    = (wr && off == 12'h008) ? wdat : 32'h0;
      ref_clr    = (wr && off == 12'h00c) ? wdat : 32'h0;
      if (wr && off == 12'h004) begin
        ref_mask = wdat;
      end
      cap_vld = csb2glb_req_pvld;
      if (csb2glb_req_pvld) begin
        cap_pd = csb2glb_req_pd;
      end
    end
  end

  // outputs are settled by the falling edge
  always @(negedge nvdla_core_clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("ERRORS FOUND");
      $finish;
    end else if (nvdla_core_rstn) begin
      check("req_prdy", 64'(csb2glb_req_prdy), 64'd1);
      check("resp_valid", 64'(glb2csb_resp_valid), 64'(exp_vld));
      if (exp_vld) begin
        check("resp_pd", 64'(glb2csb_resp_pd), 64'(exp_pd));
      end
      check("core_intr", 64'(core_intr), 64'(|(ref_status & ~ref_mask)));
      check("intr_mask", 64'(intr_mask), 64'(ref_mask));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] d;
    nvdla_core_rstn  = 1'b0;
    csb2glb_req_pvld = 1'b0;
    csb2glb_req_pd   = '0;
    {cacc_done, cdma_wt_done, cdma_dat_done, sdp_done} = 8'h00;
    test_err = 0;
    rng      = 32'hf99b_38cf;
    repeat (8) @(posedge nvdla_core_clk);
    #1;
    nvdla_core_rstn = 1'b1;

    send(1'b0, 1'b0, reg_version, 32'h0);
    send(1'b0, 1'b0, reg_intr_mask, 32'h0);
    send(1'b0, 1'b0, reg_intr_status, 32'h0);
    send(1'b0, 1'b0, 12'h010, 32'h0); // unmapped
    send(1'b0, 1'b0, 12'hffc, 32'h0);
    end_test("reset values");

    repeat (8) begin
      rng = xorshift(rng);
      send(1'b1, 1'b1, reg_intr_mask, rng);
      send(1'b0, 1'b0, reg_intr_mask, 32'h0);
    end
    end_test("mask write and read back");

    rng = xorshift(rng);
    send(1'b1, 1'b1, reg_intr_mask, rng);
    repeat (16) begin
      rng = xorshift(rng);
      drive(1'b1, make_req(1'b0, 1'b0, reg_intr_status, 32'h0), rng[7:0] & rng[15:8]);
    end
    send(1'b1, 1'b1, reg_intr_mask, 32'h0); // unmask all
    end_test("done pulses set status");

    send(1'b1, 1'b1, reg_intr_status, 32'hffff_ffff);
    idle(1);
    drive(1'b0, 63'h0, 8'h40); // cacc group 0 with the clear pulse
    idle(1);
    send(1'b0, 1'b0, reg_intr_status, 32'h0);
    drive(1'b0, 63'h0, 8'hff);
    rng = xorshift(rng);
    send(1'b1, 1'b1, reg_intr_status, rng);
    idle(1);
    send(1'b0, 1'b0, reg_intr_status, 32'h0);
    end_test("status write one to clear");

    send(1'b1, 1'b1, reg_intr_status, 32'hffff_ffff);
    idle(1);
    rng = xorshift(rng);
    send(1'b1, 1'b1, reg_intr_set, rng);
    send(1'b0, 1'b0, reg_intr_set, 32'h0);
    idle(1);
    send(1'b0, 1'b0, reg_intr_status, 32'h0);
    end_test("set register");

    rng = xorshift(rng);
    send(1'b1, 1'b0, reg_intr_mask, rng); // posted
    send(1'b0, 1'b0, reg_intr_mask, 32'h0);
    repeat (12) begin
      d   = rng;
      rng = xorshift(rng);
      send(rng[2], rng[3], {8'h00, rng[1:0], 2'b00}, d);
    end
    end_test("posted write and back to back");

    $display("%0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
